// ==== build.f ====
+incdir+verilog
verilog/bfs_pkg.sv
verilog/bram_read_first.sv
verilog/visited.sv
verilog/vertex_queue.sv
verilog/adjacency_store.sv
verilog/edge_walker.sv
verilog/bfs_ctrl.sv
verilog/bfs_top.sv
verif/bfs_tb.sv

// ==== verif/bfs_tb.sv ====
`timescale 1ns/1ps
`include "bfs_defs.svh"

module bfs_tb;
    import bfs_pkg::*;

    localparam int WAIT_LIMIT = 5000;
    localparam int DONE_LIMIT = 200000;

    logic      clk_in = 1'b0;
    logic      rst_in;
    logic      row_wr;
    vertex_t   row_vertex;
    edge_idx_t row_start;
    degree_t   row_degree;
    logic      edge_wr;
    edge_idx_t edge_addr;
    vertex_t   edge_dest;
    logic      start;
    vertex_t   root;
    logic      visit;
    vertex_t   visit_vertex;
    logic      done;
    count_t    visit_count;
    logic      busy;

    // graph image in compressed-row form
    int nv;
    int ne;
    int cur_row;
    int row_start_a [`BFS_NUM_VERTICES];
    int row_deg_a [`BFS_NUM_VERTICES];
    int dest_a [`BFS_NUM_EDGES];
    // expected visit order of the current run
    int exp_order [`BFS_NUM_VERTICES];
    int exp_len;
    int exp_pos;
    bit seen [`BFS_NUM_VERTICES];
    bit done_seen;
    bit root_seen;
    // expected busy level
    bit busy_ref = 1'b0;
    integer seed;

    bfs_top dut (.*);

    // 100 ns period
    always #50 clk_in = ~clk_in;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input int got, input int exp);
        abort_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // monitor samples DUT outputs on the rising edge
    always @(posedge clk_in) begin
        if (!rst_in) begin
            assert (busy == busy_ref) else value_error("busy", busy, busy_ref);
            // strobes only inside a run
            if (!busy_ref) begin
                assert (!visit && !done) else abort_run("visit or done strobe while idle");
            end
            if (visit) begin
                assert (exp_pos < exp_len)
                    else abort_run("more visits than reachable vertices");
                assert (!seen[visit_vertex])
                    else abort_run($sformatf("vertex 0x%0h reported twice", visit_vertex));
                assert (visit_vertex == exp_order[exp_pos])
                    else value_error("visit_vertex", visit_vertex, exp_order[exp_pos]);
                seen[visit_vertex] = 1'b1;
                exp_pos++;
                root_seen <= 1'b1;
            end
            if (done) begin
                assert (visit_count == exp_len)
                    else value_error("visit_count", visit_count, exp_len);
                assert (exp_pos == exp_len)
                    else value_error("visit strobe count", exp_pos, exp_len);
                done_seen <= 1'b1;
            end
            // accepted start raises busy in the next cycle
            // done is the last busy cycle
            if (start && !busy_ref) begin
                busy_ref = 1'b1;
            end else if (done) begin
                busy_ref = 1'b0;
            end
        end
    end

    task automatic open_row(input int v);
        cur_row        = v;
        row_start_a[v] = ne;
        row_deg_a[v]   = 0;
    endtask

    task automatic add_edge(input int d);
        dest_a[ne] = d;
        ne++;
        row_deg_a[cur_row]++;
    endtask

    // cycle 0-1 and self-loop on 2
    // duplicate 0->2, zero-degree 3 and 7
    // 6 unreachable from 0
    task automatic build_hand_graph();
        nv = 8;
        ne = 0;
        open_row(0);
        add_edge(1);
        add_edge(2);
        add_edge(2);
        open_row(1);
        add_edge(3);
        add_edge(0);
        open_row(2);
        add_edge(2);
        add_edge(4);
        open_row(3);
        open_row(4);
        add_edge(5);
        add_edge(1);
        open_row(5);
        add_edge(3);
        open_row(6);
        add_edge(0);
        open_row(7);
    endtask

    // small vertex counts give loops and repeated edges by chance
    task automatic build_random_graph(input int n);
        int deg;
        nv = n;
        ne = 0;
        for (int v = 0; v < n; v++) begin
            open_row(v);
            deg = $unsigned($random(seed)) % 7;
            for (int k = 0; k < deg; k++) begin
                add_edge($unsigned($random(seed)) % n);
            end
        end
    endtask

    task automatic load_graph();
        for (int v = 0; v < nv; v++) begin
            @(posedge clk_in);
            row_wr     <= 1'b1;
            row_vertex <= vertex_t'(v);
            row_start  <= edge_idx_t'(row_start_a[v]);
            row_degree <= degree_t'(row_deg_a[v]);
        end
        @(posedge clk_in);
        row_wr <= 1'b0;
        for (int e = 0; e < ne; e++) begin
            @(posedge clk_in);
            edge_wr   <= 1'b1;
            edge_addr <= edge_idx_t'(e);
            edge_dest <= vertex_t'(dest_a[e]);
        end
        @(posedge clk_in);
        edge_wr <= 1'b0;
    endtask

    // reference BFS with neighbours in row order and a FIFO frontier
    task automatic compute_expected(input int r);
        bit mark [`BFS_NUM_VERTICES];
        int q [$];
        int v;
        int d;
        foreach (mark[i]) begin
            mark[i] = 1'b0;
        end
        q.delete();
        exp_len        = 1;
        exp_order[0]   = r;
        mark[r]        = 1'b1;
        q.push_back(r);
        while (q.size() > 0) begin
            v = q.pop_front();
            for (int i = 0; i < row_deg_a[v]; i++) begin
                d = dest_a[row_start_a[v] + i];
                if (!mark[d]) begin
                    mark[d]            = 1'b1;
                    exp_order[exp_len] = d;
                    exp_len++;
                    q.push_back(d);
                end
            end
        end
    endtask

    // poke sends a second start just after the root visit
    task automatic run_traversal(input int r, input bit poke);
        int cycles;
        compute_expected(r);
        exp_pos   = 0;
        done_seen <= 1'b0;
        root_seen <= 1'b0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        @(posedge clk_in);
        start <= 1'b1;
        root  <= vertex_t'(r);
        @(posedge clk_in);
        start <= 1'b0;
        if (poke) begin
            cycles = 0;
            while (!root_seen && cycles < WAIT_LIMIT) begin
                @(posedge clk_in);
                cycles++;
            end
            if (!root_seen) begin
                abort_run("timeout waiting for the root visit");
            end
            start <= 1'b1;
            root  <= vertex_t'(r ^ 1);
            @(posedge clk_in);
            start <= 1'b0;
        end
        cycles = 0;
        while (!done_seen && cycles < DONE_LIMIT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (!done_seen) begin
            abort_run("timeout waiting for done");
        end
    endtask

    initial begin
        int r1;
        int r2;
        int n;
        seed       = 32'hc5018117;
        rst_in     = 1'b1;
        row_wr     = 1'b0;
        row_vertex = '0;
        row_start  = '0;
        row_degree = '0;
        edge_wr    = 1'b0;
        edge_addr  = '0;
        edge_dest  = '0;
        start      = 1'b0;
        root       = '0;
        exp_len    = 0;
        exp_pos    = 0;
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
        // quiet time after reset
        repeat (10) @(posedge clk_in);

        build_hand_graph();
        load_graph();
        run_traversal(0, 1'b0);
        // different root on the same graph needs a clean bitmap
        run_traversal(6, 1'b1);

        for (int g = 0; g < 3; g++) begin
            n = (g == 2) ? 300 : 40;
            build_random_graph(n);
            load_graph();
            r1 = $unsigned($random(seed)) % n;
            r2 = (r1 + 1 + $unsigned($random(seed)) % (n - 1)) % n;
            run_traversal(r1, 1'b1);
            run_traversal(r2, 1'b0);
        end

        repeat (4) @(posedge clk_in);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verilog/bfs_top.sv ====
`timescale 1ns/1ps

module bfs_top (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               row_wr,
    input  bfs_pkg::vertex_t   row_vertex,
    input  bfs_pkg::edge_idx_t row_start,
    input  bfs_pkg::degree_t   row_degree,
    input  logic               edge_wr,
    input  bfs_pkg::edge_idx_t edge_addr,
    input  bfs_pkg::vertex_t   edge_dest,
    input  logic               start,
    input  bfs_pkg::vertex_t   root,
    output logic               visit,
    output bfs_pkg::vertex_t   visit_vertex,
    output logic               done,
    output bfs_pkg::count_t    visit_count,
    output logic               busy
);
    import bfs_pkg::*;

    // visited bitmap
    logic      check;
    logic      clear;
    vertex_t   check_vertex;
    logic      was_visited;
    logic      result_valid;
    // frontier queue
    logic      push;
    logic      pop;
    vertex_t   push_vertex;
    vertex_t   head_vertex;
    logic      empty;
    // adjacency reads
    vertex_t   rd_vertex;
    edge_idx_t rd_edge;
    edge_idx_t rd_start;
    degree_t   rd_degree;
    vertex_t   rd_dest;
    // walker
    logic      walk_load;
    logic      walk_step;
    edge_idx_t walk_base;
    degree_t   walk_length;
    edge_idx_t walk_index;
    logic      walk_last;
    logic      walk_none;

    bfs_ctrl ctrl (.*);

    visited visited_map (
        .clk_in, .rst_in, .check_vertex, .check, .clear, .was_visited, .result_valid
    );

    vertex_queue frontier (
        .clk_in, .rst_in, .push, .pop, .push_vertex, .head_vertex, .empty
    );

    adjacency_store graph (
        .clk_in, .rst_in,
        .row_wr, .row_vertex, .row_start, .row_degree,
        .edge_wr, .edge_addr, .edge_dest,
        .rd_vertex, .rd_edge, .rd_start, .rd_degree, .rd_dest
    );

    edge_walker walker (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .load       (walk_load),
        .step       (walk_step),
        .base       (walk_base),
        .length     (walk_length),
        .index      (walk_index),
        .last       (walk_last),
        .none       (walk_none)
    );

endmodule

// ==== verilog/bfs_ctrl.sv ====
`timescale 1ns/1ps
`include "bfs_defs.svh"

module bfs_ctrl (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               start,
    input  bfs_pkg::vertex_t   root,
    output logic               check,
    output logic               clear,
    output bfs_pkg::vertex_t   check_vertex,
    input  logic               was_visited,
    input  logic               result_valid,
    output logic               push,
    output logic               pop,
    output bfs_pkg::vertex_t   push_vertex,
    input  bfs_pkg::vertex_t   head_vertex,
    input  logic               empty,
    output bfs_pkg::vertex_t   rd_vertex,
    output bfs_pkg::edge_idx_t rd_edge,
    input  bfs_pkg::edge_idx_t rd_start,
    input  bfs_pkg::degree_t   rd_degree,
    input  bfs_pkg::vertex_t   rd_dest,
    output logic               walk_load,
    output logic               walk_step,
    output bfs_pkg::edge_idx_t walk_base,
    output bfs_pkg::degree_t   walk_length,
    input  bfs_pkg::edge_idx_t walk_index,
    input  logic               walk_last,
    input  logic               walk_none,
    output logic               visit,
    output bfs_pkg::vertex_t   visit_vertex,
    output logic               done,
    output bfs_pkg::count_t    visit_count,
    output logic               busy
);
    import bfs_pkg::*;

    bfs_state_t state;
    // vertex being checked, root or edge destination
    vertex_t    target;
    count_t     count;
    // check issued, answer not back yet
    logic       pending;
    // RAM latency counter for row and edge reads
    logic [1:0] wait_cnt;
    logic       mem_ready;
    logic       checking;
    logic       answer;
    logic       fresh;

    assign mem_ready = (wait_cnt == 2'd2);
    assign checking  = (state == st_seed) || (state == st_edge_check);
    assign answer    = checking && result_valid;
    // newly discovered vertex
    assign fresh     = answer && !was_visited;

    // visited bitmap
    assign check        = checking && !pending;
    assign clear        = (state == st_clear);
    assign check_vertex = clear ? walk_index[`BFS_VERTEX_BITS-1:0] : target;

    // each discovery is pushed and announced in the same cycle
    assign push         = fresh;
    assign push_vertex  = target;
    assign visit        = fresh;
    assign visit_vertex = target;
    assign pop          = (state == st_pop) && !empty;

    // head stays put until the next pop, so it drives the row read
    assign rd_vertex = head_vertex;
    assign rd_edge   = walk_index;

    // idle loads the clear sweep, row_read loads the row
    assign walk_load   = ((state == st_idle) && start) || ((state == st_row_read) && mem_ready);
    assign walk_base   = (state == st_idle) ? '0 : rd_start;
    assign walk_length = (state == st_idle) ? degree_t'(`BFS_NUM_VERTICES) : rd_degree;
    assign walk_step   = clear || (answer && (state == st_edge_check));

    assign done        = (state == st_finish);
    assign busy        = (state != st_idle);
    assign visit_count = count;

    always_ff @(posedge clk_in) begin
        if ((state == st_idle) && start) begin
            target <= root;
        end else if ((state == st_edge_read) && mem_ready) begin
            target <= rd_dest;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= st_idle;
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            count    <= '0;
        end else begin
            if (check) begin
                pending <= 1'b1;
            end else if (result_valid) begin
                pending <= 1'b0;
            end
            if (fresh) begin
                count <= count + 1'b1;
            end
            case (state)
                st_idle: begin
                    // start while busy never reaches here
                    if (start) begin
                        count <= '0;
                        state <= st_clear;
                    end
                end
                // one bitmap entry per cycle
                st_clear: begin
                    if (walk_last) begin
                        state <= st_seed;
                    end
                end
                st_seed: begin
                    if (result_valid) begin
                        state <= st_pop;
                    end
                end
                st_pop: begin
                    wait_cnt <= 2'd0;
                    state    <= empty ? st_finish : st_row_read;
                end
                st_row_read: begin
                    if (mem_ready) begin
                        wait_cnt <= 2'd0;
                        state    <= st_edge_read;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_edge_read: begin
                    // empty row, go to the next vertex
                    if (walk_none) begin
                        wait_cnt <= 2'd0;
                        state    <= st_pop;
                    end else if (mem_ready) begin
                        wait_cnt <= 2'd0;
                        state    <= st_edge_check;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_edge_check: begin
                    if (result_valid) begin
                        state <= walk_last ? st_pop : st_edge_read;
                    end
                end
                st_finish: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

endmodule

// ==== verilog/edge_walker.sv ====
`timescale 1ns/1ps

module edge_walker (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               load,
    input  logic               step,
    input  bfs_pkg::edge_idx_t base,
    input  bfs_pkg::degree_t   length,
    output bfs_pkg::edge_idx_t index,
    output logic               last,
    output logic               none
);
    import bfs_pkg::*;

    // elements left, current one included
    degree_t remaining;

    assign last = (remaining == degree_t'(1));
    // zero-length row right after load
    assign none = (remaining == '0);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            index     <= '0;
            remaining <= '0;
        end else if (load) begin
            index     <= base;
            remaining <= length;
        end else if (step && !none) begin
            index     <= index + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

endmodule

// ==== verilog/adjacency_store.sv ====
`timescale 1ns/1ps
`include "bfs_defs.svh"

module adjacency_store (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               row_wr,
    input  bfs_pkg::vertex_t   row_vertex,
    input  bfs_pkg::edge_idx_t row_start,
    input  bfs_pkg::degree_t   row_degree,
    input  logic               edge_wr,
    input  bfs_pkg::edge_idx_t edge_addr,
    input  bfs_pkg::vertex_t   edge_dest,
    input  bfs_pkg::vertex_t   rd_vertex,
    input  bfs_pkg::edge_idx_t rd_edge,
    output bfs_pkg::edge_idx_t rd_start,
    output bfs_pkg::degree_t   rd_degree,
    output bfs_pkg::vertex_t   rd_dest
);
    import bfs_pkg::*;

    vertex_t   row_addr;
    edge_idx_t edge_ram_addr;

    // host write takes the port, else controller read
    assign row_addr      = row_wr ? row_vertex : rd_vertex;
    assign edge_ram_addr = edge_wr ? edge_addr : rd_edge;

    // first edge index of each row
    bram_read_first #(
        .RAM_WIDTH(`BFS_EDGE_BITS),
        .RAM_DEPTH(`BFS_NUM_VERTICES)
    ) start_ram (
        .clk_in (clk_in), .rst_in (rst_in), .addr (row_addr),
        .din (row_start), .we (row_wr), .dout (rd_start)
    );

    // edge count of each row
    bram_read_first #(
        .RAM_WIDTH(`BFS_VERTEX_BITS + 1),
        .RAM_DEPTH(`BFS_NUM_VERTICES)
    ) degree_ram (
        .clk_in (clk_in), .rst_in (rst_in), .addr (row_addr),
        .din (row_degree), .we (row_wr), .dout (rd_degree)
    );

    // destination vertex of each edge
    bram_read_first #(
        .RAM_WIDTH(`BFS_VERTEX_BITS),
        .RAM_DEPTH(`BFS_NUM_EDGES)
    ) dest_ram (
        .clk_in (clk_in), .rst_in (rst_in), .addr (edge_ram_addr),
        .din (edge_dest), .we (edge_wr), .dout (rd_dest)
    );

endmodule

// ==== verilog/vertex_queue.sv ====
`timescale 1ns/1ps
`include "bfs_defs.svh"

module vertex_queue (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             push,
    input  logic             pop,
    input  bfs_pkg::vertex_t push_vertex,
    output bfs_pkg::vertex_t head_vertex,
    output logic             empty
);
    import bfs_pkg::*;

    vertex_t                     mem [`BFS_NUM_VERTICES];
    // depth is a power of two, pointers wrap on their own
    logic [`BFS_VERTEX_BITS-1:0] wr_ptr;
    logic [`BFS_VERTEX_BITS-1:0] rd_ptr;
    // occupancy, one bit wider for a full queue
    logic [`BFS_VERTEX_BITS:0]   fill;

    assign empty = (fill == '0);

    // storage and head register
    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_vertex;
        end
        // head shows up the cycle after pop
        if (pop) begin
            head_vertex <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together keep the count
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

// ==== verilog/visited.sv ====
`timescale 1ns/1ps
`include "bfs_defs.svh"

module visited (
    input  logic             clk_in,
    input  logic             rst_in,
    input  bfs_pkg::vertex_t check_vertex,
    input  logic             check,
    input  logic             clear,
    output logic             was_visited,
    output logic             result_valid
);
    import bfs_pkg::*;

    // vertex of the request, kept for the write-back
    vertex_t    addr_q;
    // 0 idle, 1..2 waiting on the RAM, 3 marking
    logic [1:0] phase;
    logic       set_we;
    logic       ram_we;
    logic       ram_din;
    vertex_t    ram_addr;
    logic       ram_dout;

    // a fresh request goes to the RAM in its own cycle
    assign ram_addr = (check || clear) ? check_vertex : addr_q;
    assign ram_we   = set_we || clear;
    // clear writes 0, mark writes 1
    assign ram_din  = !clear;

    always_ff @(posedge clk_in) begin
        if (check) begin
            addr_q <= check_vertex;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            phase        <= 2'd0;
            set_we       <= 1'b0;
            result_valid <= 1'b0;
            was_visited  <= 1'b0;
        end else begin
            // answer is a single-cycle strobe
            result_valid <= 1'b0;
            if (check) begin
                phase <= 2'd1;
            end else if (phase == 2'd1) begin
                phase <= 2'd2;
            end else if (phase == 2'd2) begin
                // RAM output now holds the bit read at check
                if (ram_dout) begin
                    result_valid <= 1'b1;
                    was_visited  <= 1'b1;
                    phase        <= 2'd0;
                end else begin
                    set_we <= 1'b1;
                    phase  <= 2'd3;
                end
            end else if (phase == 2'd3) begin
                // mark written this cycle, report new vertex
                set_we       <= 1'b0;
                result_valid <= 1'b1;
                was_visited  <= 1'b0;
                phase        <= 2'd0;
            end
        end
    end

    bram_read_first #(
        .RAM_WIDTH(1),
        .RAM_DEPTH(`BFS_NUM_VERTICES)
    ) bitmap_ram (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .addr   (ram_addr),
        .din    (ram_din),
        .we     (ram_we),
        .dout   (ram_dout)
    );

endmodule

// ==== verilog/bram_read_first.sv ====
`timescale 1ns/1ps

module bram_read_first #(
    parameter int RAM_WIDTH = 1,
    parameter int RAM_DEPTH = 1024
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic [$clog2(RAM_DEPTH)-1:0] addr,
    input  logic [RAM_WIDTH-1:0]         din,
    input  logic                         we,
    output logic [RAM_WIDTH-1:0]         dout
);

    logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];
    // first stage, array read
    logic [RAM_WIDTH-1:0] ram_q;

    // read-first: old contents come out on a write
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[addr] <= din;
        end
        ram_q <= mem[addr];
    end

    // output stage, second cycle of latency
    // only this register sees reset, contents are kept
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dout <= '0;
        end else begin
            dout <= ram_q;
        end
    end

endmodule

// ==== verilog/bfs_pkg.sv ====
`include "bfs_defs.svh"

package bfs_pkg;

    // vertex id
    typedef logic [`BFS_VERTEX_BITS-1:0] vertex_t;

    // index into the edge RAM
    typedef logic [`BFS_EDGE_BITS-1:0] edge_idx_t;

    // edges in one row, one bit wider so a full row of 1024 fits
    typedef logic [`BFS_VERTEX_BITS:0] degree_t;

    // visited vertices per run, can reach 1024
    typedef logic [`BFS_VERTEX_BITS:0] count_t;

    // traversal controller states
    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_seed,
        st_pop,
        st_row_read,
        st_edge_read,
        st_edge_check,
        st_finish
    } bfs_state_t;

endpackage

// ==== verilog/bfs_defs.svh ====
`ifndef BFS_DEFS_SVH
`define BFS_DEFS_SVH

// vertex id width
// 1024 vertices fits one visited RAM
`define BFS_VERTEX_BITS 10

// edge index width, 4096 edges
`define BFS_EDGE_BITS 12

// depth of the row RAMs, the visited bitmap and the frontier
`define BFS_NUM_VERTICES 1024

// depth of the edge destination RAM
`define BFS_NUM_EDGES 4096

`endif
